/* files.f */
+incdir+design
design/rv_wb_pkg.sv
design/wb_if.sv
design/wb_result_sel.sv
design/gpr_file.sv
design/store_fsm.sv
design/wb_stage.sv
tb/wb_stage_assert.sv
tb/tb_wb_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_wb_stage
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST)) $(wildcard design/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	elif ! grep -q "=== PASS ===" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb/tb_wb_stage.sv */
`include "rv_wb_params.svh"

module tb_wb_stage;
    import rv_wb_pkg::*;

    localparam int TIMEOUT = 200; // cycles allowed per wait

    logic      clk;
    logic      rst_n;
    logic      wb_valid;
    logic      is_store;
    reg_idx_t  reg_idx;
    xlen_t     ex_res;
    xlen_t     mem_res;
    ld_src_t   ld_src;
    logic      fwd_hazard;
    ext_mode_t ext_mode;
    imm_t      s_imm;
    wmask_t    wmask;
    reg_idx_t  dbg_idx;
    xlen_t     dbg_data;
    logic      mem_wdone;
    logic      mem_bresp;
    logic      mem_wvalid;
    xlen_t     mem_waddr;
    xlen_t     mem_wdata;
    wmask_t    mem_wmask;
    logic      wb_ready;

    xlen_t  shadow [`RV_REG_NUM]; // expected register contents
    xlen_t  cap_addr;              // last write seen by the bus slave
    xlen_t  cap_data;
    wmask_t cap_mask;
    integer seed = 81;
    int     value_errs = 0;
    int     protocol_errs = 0;
    int     timeouts = 0;

    wb_stage i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_valid   (wb_valid),
        .is_store   (is_store),
        .reg_idx    (reg_idx),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .ld_src     (ld_src),
        .fwd_hazard (fwd_hazard),
        .ext_mode   (ext_mode),
        .s_imm      (s_imm),
        .wmask      (wmask),
        .dbg_idx    (dbg_idx),
        .dbg_data   (dbg_data),
        .mem_wdone  (mem_wdone),
        .mem_bresp  (mem_bresp),
        .mem_wvalid (mem_wvalid),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask),
        .wb_ready   (wb_ready)
    );

    always #4 clk = ~clk;

    task automatic finish_run();
        $display("summary: %0d value errors, %0d protocol errors, %0d timeouts",
                 value_errs, protocol_errs, timeouts);
        if (value_errs == 0 && protocol_errs == 0 && timeouts == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    endtask

    task automatic timed_out(string what);
        timeouts++;
        $display("ERROR at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        finish_run();
    endtask

    task automatic protocol_error(string msg);
        protocol_errs++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_xlen(string what, xlen_t got, xlen_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_mask(string what, wmask_t got, wmask_t exp);
        if (got !== exp) begin
            value_errs++;
            $display("FAILED @%0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // memory result only for load codes without a forwarding hazard
    function automatic logic picks_memory(ld_src_t code, logic haz);
        case (code)
            3'd1, 3'd2, 3'd4, 3'd6: return !haz;
            default:                return 1'b0;
        endcase
    endfunction

    function automatic xlen_t extend_expected(xlen_t v, logic [3:0] mode);
        logic signed [31:0] word;
        logic signed [15:0] half;
        word = v[31:0];
        half = v[15:0];
        case (mode)
            4'd0:    return v;
            4'd1:    return xlen_t'(word); // signed cast widens with the sign
            4'd3:    return xlen_t'(half);
            default: return xlen_t'(v[31:0]);
        endcase
    endfunction

    function automatic xlen_t store_addr(xlen_t base, imm_t imm);
        logic signed [`RV_IMM_W-1:0] off;
        off = imm;
        return base + xlen_t'(off);
    endfunction

    // one cycle of wb_valid with the given instruction fields
    task automatic present_instr(logic store, reg_idx_t idx, xlen_t ex, xlen_t mem,
                                 ld_src_t src, logic haz, ext_mode_t ext,
                                 imm_t imm, wmask_t mask);
        @(posedge clk);
        wb_valid   <= 1'b1;
        is_store   <= store;
        reg_idx    <= idx;
        ex_res     <= ex;
        mem_res    <= mem;
        ld_src     <= src;
        fwd_hazard <= haz;
        ext_mode   <= ext;
        s_imm      <= imm;
        wmask      <= mask;
        @(posedge clk);
        wb_valid <= 1'b0; // sampled high at this edge
        is_store <= 1'b0;
    endtask

    task automatic write_reg(reg_idx_t idx, xlen_t val);
        present_instr(1'b0, idx, val, '0, 3'd0, 1'b0, EXT_NONE, '0, '0);
        if (idx != '0) begin
            shadow[idx] = val;
        end
    endtask

    task automatic read_check(reg_idx_t idx, string what);
        @(posedge clk);
        dbg_idx <= idx;
        @(negedge clk);
        check_xlen(what, dbg_data, shadow[idx]);
    endtask

    task automatic wait_ready();
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (wb_ready !== 1'b1) begin
            if (cyc >= TIMEOUT) begin
                timed_out("wb_ready");
            end
            @(negedge clk);
            cyc++;
        end
    endtask

    // store whose data must leave unextended despite the halfword mode
    task automatic issue_store(reg_idx_t base, imm_t imm, xlen_t data, wmask_t mask);
        present_instr(1'b1, base, data, '0, 3'd0, 1'b0, EXT_H_SIGN, imm, mask);
        @(negedge clk);
        if (mem_wvalid !== 1'b1) begin
            protocol_error("mem_wvalid not raised on the cycle after the store");
        end
    endtask

    // bus slave, done and response come after the given idle cycles
    task automatic bus_slave(int done_dly, int resp_dly);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (mem_wvalid !== 1'b1) begin
            if (cyc >= TIMEOUT) begin
                timed_out("mem_wvalid");
            end
            @(negedge clk);
            cyc++;
        end
        cap_addr = mem_waddr;
        cap_data = mem_wdata;
        cap_mask = mem_wmask;
        repeat (done_dly) begin
            @(negedge clk);
            if (wb_ready !== 1'b0) begin
                protocol_error("wb_ready high while the write data was pending");
            end
        end
        @(posedge clk);
        mem_wdone <= 1'b1;
        @(posedge clk);
        mem_wdone <= 1'b0;
        repeat (resp_dly) begin
            @(negedge clk);
            if (wb_ready !== 1'b0 || mem_wvalid !== 1'b0) begin
                protocol_error("wb_ready or mem_wvalid high while waiting for the response");
            end
        end
        @(posedge clk);
        mem_bresp <= 1'b1;
        @(posedge clk);
        mem_bresp <= 1'b0;
    endtask

    task automatic test_result_select();
        reg_idx_t idx;
        xlen_t    ex;
        xlen_t    mem;
        for (int code = 0; code < 8; code++) begin
            for (int haz = 0; haz < 2; haz++) begin
                idx = reg_idx_t'(2 + code * 2 + haz); // x2..x17
                ex  = {$random(seed), $random(seed)};
                mem = ~ex;
                present_instr(1'b0, idx, ex, mem, ld_src_t'(code), haz[0], EXT_NONE, '0, '0);
                shadow[idx] = picks_memory(ld_src_t'(code), haz[0]) ? mem : ex;
                read_check(idx, $sformatf("x%0d ld_src %0d hazard %0d", idx, code, haz));
            end
        end
    endtask

    task automatic test_extension();
        reg_idx_t   idx;
        xlen_t      v;
        logic [3:0] mode;
        for (int i = 0; i < 5; i++) begin
            idx  = reg_idx_t'(18 + i);
            mode = (i == 4) ? 4'd9 : i[3:0]; // last one is undefined
            v    = {$random(seed), $random(seed)} | 64'h8000_0000_8000_8000;
            present_instr(1'b0, idx, v, '0, 3'd0, 1'b0, ext_mode_t'(mode), '0, '0);
            shadow[idx] = extend_expected(v, mode);
            read_check(idx, $sformatf("x%0d ext mode %0d", idx, mode));
        end
    endtask

    task automatic test_x0();
        xlen_t val;
        val = {$random(seed), $random(seed)};
        write_reg('0, val);
        read_check('0, "x0 after a write");
        read_check(5'd2, "x2 after the x0 write");
        present_instr(1'b1, '0, val, '0, 3'd0, 1'b0, EXT_NONE, 32'h10, 8'hff);
        for (int cyc = 0; cyc < 12; cyc++) begin
            @(negedge clk);
            if (mem_wvalid !== 1'b0 || wb_ready !== 1'b1) begin
                protocol_error("bus activity for a store with base x0");
            end
        end
    endtask

    task automatic test_store();
        reg_idx_t base;
        imm_t     imm;
        xlen_t    data;
        wmask_t   mask;
        for (int i = 0; i < 4; i++) begin
            base = reg_idx_t'(24 + i);
            case (i)
                0:       imm = 32'h0000_0010;
                1:       imm = 32'hFFFF_FFF8; // small negative offset
                2:       imm = 32'h7FFF_F000;
                default: imm = 32'h8000_0000;
            endcase
            write_reg(base, {$random(seed), $random(seed)});
            data = {$random(seed), $random(seed)};
            mask = wmask_t'($random(seed));
            issue_store(base, imm, data, mask);
            bus_slave(i, 3 - i);
            wait_ready();
            check_xlen("store address", cap_addr, store_addr(shadow[base], imm));
            check_xlen("store data", cap_data, data);
            check_mask("store mask", cap_mask, mask);
            read_check(base, "store base register after the store");
        end
    endtask

    task automatic test_backpressure();
        xlen_t old_val;
        xlen_t new_val;
        xlen_t data;
        old_val = {$random(seed), $random(seed)};
        new_val = ~old_val;
        data    = {$random(seed), $random(seed)};
        write_reg(5'd29, old_val);
        write_reg(5'd28, {$random(seed), $random(seed)});
        issue_store(5'd28, 32'h40, data, 8'h0f);
        // stage is busy, this write must be dropped
        present_instr(1'b0, 5'd29, new_val, '0, 3'd0, 1'b0, EXT_NONE, '0, '0);
        bus_slave(6, 5);
        wait_ready();
        check_xlen("slow store address", cap_addr, store_addr(shadow[5'd28], 32'h40));
        check_xlen("slow store data", cap_data, data);
        read_check(5'd29, "x29 after a write during busy");
        write_reg(5'd29, new_val); // replayed once ready
        read_check(5'd29, "x29 after the replayed write");
    endtask

    initial begin
        clk        = 1'b0;
        rst_n      = 1'b0;
        wb_valid   = 1'b0;
        is_store   = 1'b0;
        reg_idx    = '0;
        ex_res     = '0;
        mem_res    = '0;
        ld_src     = '0;
        fwd_hazard = 1'b0;
        ext_mode   = EXT_NONE;
        s_imm      = '0;
        wmask      = '0;
        dbg_idx    = '0;
        mem_wdone  = 1'b0;
        mem_bresp  = 1'b0;
        foreach (shadow[i]) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        test_result_select();
        test_extension();
        test_x0();
        test_store();
        test_backpressure();
        finish_run();
    end

endmodule

/* tb/wb_stage_assert.sv */
module wb_stage_assert (
    input logic              clk,
    input logic              rst_n,
    input logic              mem_wdone,
    input logic              mem_bresp,
    input logic              mem_wvalid,
    input rv_wb_pkg::xlen_t  mem_waddr,
    input rv_wb_pkg::xlen_t  mem_wdata,
    input rv_wb_pkg::wmask_t mem_wmask,
    input logic              wb_ready
);

    // write valid is a level held until the slave reports done
    wvalid_held: assert property (
        @(posedge clk) disable iff (!rst_n)
        mem_wvalid && !mem_wdone |=> mem_wvalid
    ) else $error("mem_wvalid dropped before mem_wdone");

    payload_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_wvalid && $past(mem_wvalid)) |-> $stable({mem_waddr, mem_wdata, mem_wmask})
    ) else $error("write address, data or mask changed while mem_wvalid was high");

    // stall holds until the response pulse
    ready_after_resp: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wb_ready && !mem_bresp |=> !wb_ready
    ) else $error("wb_ready returned without mem_bresp");

endmodule

bind store_fsm wb_stage_assert i_store_assert (
    .clk        (clk),
    .rst_n      (rst_n),
    .mem_wdone  (mem_wdone),
    .mem_bresp  (mem_bresp),
    .mem_wvalid (mem_wvalid),
    .mem_waddr  (mem_waddr),
    .mem_wdata  (mem_wdata),
    .mem_wmask  (mem_wmask),
    .wb_ready   (wb_ready)
);

/* design/wb_stage.sv */
module wb_stage (
    input  logic                 clk,
    input  logic                 rst_n,

    // retiring instruction from the previous stage
    input  logic                 wb_valid,
    input  logic                 is_store,
    input  rv_wb_pkg::reg_idx_t  reg_idx,
    input  rv_wb_pkg::xlen_t     ex_res,
    input  rv_wb_pkg::xlen_t     mem_res,
    input  rv_wb_pkg::ld_src_t   ld_src,
    input  logic                 fwd_hazard,
    input  rv_wb_pkg::ext_mode_t ext_mode,
    input  rv_wb_pkg::imm_t      s_imm,
    input  rv_wb_pkg::wmask_t    wmask,

    // debug read
    input  rv_wb_pkg::reg_idx_t  dbg_idx,
    output rv_wb_pkg::xlen_t     dbg_data,

    // store write bus
    input  logic                 mem_wdone,
    input  logic                 mem_bresp,
    output logic                 mem_wvalid,
    output rv_wb_pkg::xlen_t     mem_waddr,
    output rv_wb_pkg::xlen_t     mem_wdata,
    output rv_wb_pkg::wmask_t    mem_wmask,

    output logic                 wb_ready
);

    rd_write_if  i_wr_if ();
    store_req_if i_st_if ();

    wb_result_sel i_result_sel (
        .clk        (clk),
        .rst_n      (rst_n),
        .wb_valid   (wb_valid),
        .is_store   (is_store),
        .reg_idx    (reg_idx),
        .ex_res     (ex_res),
        .mem_res    (mem_res),
        .ld_src     (ld_src),
        .fwd_hazard (fwd_hazard),
        .ext_mode   (ext_mode),
        .s_imm      (s_imm),
        .wmask      (wmask),
        .wr         (i_wr_if.src),
        .st         (i_st_if.issue)
    );

    gpr_file i_gpr_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr       (i_wr_if.dst),
        .st       (i_st_if.base),
        .dbg_idx  (dbg_idx),
        .dbg_data (dbg_data)
    );

    store_fsm i_store_fsm (
        .clk        (clk),
        .rst_n      (rst_n),
        .st         (i_st_if.engine),
        .mem_wdone  (mem_wdone),
        .mem_bresp  (mem_bresp),
        .mem_wvalid (mem_wvalid),
        .mem_waddr  (mem_waddr),
        .mem_wdata  (mem_wdata),
        .mem_wmask  (mem_wmask),
        .wb_ready   (wb_ready)
    );

endmodule

/* design/store_fsm.sv */
`include "rv_wb_params.svh"

module store_fsm (
    input  logic              clk,
    input  logic              rst_n,
    store_req_if.engine       st,
    input  logic              mem_wdone,  // pulse from the slave
    input  logic              mem_bresp,  // pulse from the slave
    output logic              mem_wvalid,
    output rv_wb_pkg::xlen_t  mem_waddr,
    output rv_wb_pkg::xlen_t  mem_wdata,
    output rv_wb_pkg::wmask_t mem_wmask,
    output logic              wb_ready
);
    import rv_wb_pkg::*;

    store_state_t state_q;
    store_state_t state_d;
    xlen_t        addr_q;
    xlen_t        data_q;
    wmask_t       mask_q;
    xlen_t        imm_sext;
    xlen_t        addr_d;

    // effective address is base plus sign-extended offset
    assign imm_sext = {{(`RV_XLEN-`RV_IMM_W){st.imm[`RV_IMM_W-1]}}, st.imm};
    assign addr_d   = st.base_val + imm_sext;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (st.start) begin
                    state_d = ST_WRITE;
                end
            end
            ST_WRITE: begin
                if (mem_wdone) begin
                    state_d = ST_WRESP;
                end
            end
            ST_WRESP: begin
                if (mem_bresp) begin
                    state_d = ST_FIN;
                end
            end
            ST_FIN:  state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // capture on accept, hold through the transfer, clear in FIN
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q <= '0;
            data_q <= '0;
            mask_q <= '0;
        end else if (state_q == ST_IDLE && st.start) begin
            addr_q <= addr_d;
            data_q <= st.data;
            mask_q <= st.mask;
        end else if (state_q == ST_FIN) begin
            addr_q <= '0;
            data_q <= '0;
            mask_q <= '0;
        end
    end

    assign mem_wvalid = (state_q == ST_WRITE);
    assign mem_waddr  = addr_q;
    assign mem_wdata  = data_q;
    assign mem_wmask  = mask_q;

    // stall upstream while the bus is in flight
    assign wb_ready = !(state_q == ST_WRITE || state_q == ST_WRESP);
    assign st.busy  = (state_q != ST_IDLE); // FIN still blocks a new request

endmodule

/* design/gpr_file.sv */
`include "rv_wb_params.svh"

module gpr_file (
    input  logic                clk,
    input  logic                rst_n,
    rd_write_if.dst             wr,
    store_req_if.base           st,
    input  rv_wb_pkg::reg_idx_t dbg_idx,
    output rv_wb_pkg::xlen_t    dbg_data
);
    import rv_wb_pkg::*;

    xlen_t regs [`RV_REG_NUM];

    // synchronous write on the strobe edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RV_REG_NUM; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we) begin
            regs[wr.idx] <= wr.data;
        end
    end

    // store base read, x0 forced to zero
    assign st.base_val = (wr.base_idx == '0) ? '0 : regs[wr.base_idx];

    // debug port for watching the register file from outside
    assign dbg_data = (dbg_idx == '0) ? '0 : regs[dbg_idx];

endmodule

/* design/wb_result_sel.sv */
`include "rv_wb_params.svh"

module wb_result_sel (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                wb_valid,
    input  logic                is_store,
    input  rv_wb_pkg::reg_idx_t reg_idx,    // rd for writes, base for stores
    input  rv_wb_pkg::xlen_t    ex_res,
    input  rv_wb_pkg::xlen_t    mem_res,
    input  rv_wb_pkg::ld_src_t  ld_src,
    input  logic                fwd_hazard,
    input  rv_wb_pkg::ext_mode_t ext_mode,
    input  rv_wb_pkg::imm_t     s_imm,
    input  rv_wb_pkg::wmask_t   wmask,
    rd_write_if.src             wr,
    store_req_if.issue          st
);
    import rv_wb_pkg::*;

    xlen_t sel_val;
    xlen_t ext_val;
    logic  use_mem;
    logic  idx_nz;

    assign use_mem = (ld_src inside {3'd1, 3'd2, 3'd4, 3'd6}) && !fwd_hazard;
    assign sel_val = use_mem ? mem_res : ex_res;
    assign idx_nz  = (reg_idx != '0);

    always_comb begin
        case (ext_mode)
            EXT_NONE:   ext_val = sel_val;
            EXT_W_SIGN: ext_val = {{(`RV_XLEN-32){sel_val[31]}}, sel_val[31:0]};
            EXT_W_ZERO: ext_val = {{(`RV_XLEN-32){1'b0}}, sel_val[31:0]};
            EXT_H_SIGN: ext_val = {{(`RV_XLEN-16){sel_val[15]}}, sel_val[15:0]};
            default:    ext_val = {{(`RV_XLEN-32){1'b0}}, sel_val[31:0]}; // treated as word zero-ext
        endcase
    end

    // x0 writes are dropped here
    assign wr.we       = wb_valid && !is_store && idx_nz && !st.busy;
    assign wr.idx      = reg_idx;
    assign wr.data     = ext_val;
    assign wr.base_idx = reg_idx;

    // store data goes out unextended
    assign st.start = wb_valid && is_store && idx_nz && !st.busy;
    assign st.imm   = s_imm;
    assign st.data  = sel_val;
    assign st.mask  = wmask;

endmodule

/* design/wb_if.sv */
// register write from result select into the register file
interface rd_write_if;
    import rv_wb_pkg::*;

    logic     we;       // one-cycle write strobe
    reg_idx_t idx;
    xlen_t    data;
    reg_idx_t base_idx; // store base read address

    modport src (
        output we, idx, data, base_idx
    );

    modport dst (
        input we, idx, data, base_idx
    );
endinterface

// store request from result select to the store engine
interface store_req_if;
    import rv_wb_pkg::*;

    logic   start;    // one-cycle strobe, only while busy is low
    xlen_t  base_val; // base register value from the register file
    imm_t   imm;
    xlen_t  data;
    wmask_t mask;
    logic   busy;

    modport issue (
        output start, imm, data, mask,
        input  busy
    );

    modport base (
        output base_val
    );

    modport engine (
        input  start, base_val, imm, data, mask,
        output busy
    );
endinterface

/* design/rv_wb_pkg.sv */
`include "rv_wb_params.svh"

package rv_wb_pkg;

    typedef logic [`RV_XLEN-1:0]      xlen_t;
    typedef logic [`RV_REG_IDX_W-1:0] reg_idx_t;
    typedef logic [`RV_MASK_W-1:0]    wmask_t;
    typedef logic [`RV_IMM_W-1:0]     imm_t;

    // result source code, 1/2/4/6 select the memory result
    typedef logic [2:0] ld_src_t;

    // width extension applied before the register write
    typedef enum logic [3:0] {
        EXT_NONE   = 4'd0, // jalr and full width ops
        EXT_W_SIGN = 4'd1, // lw, addw and friends
        EXT_W_ZERO = 4'd2,
        EXT_H_SIGN = 4'd3  // lh
    } ext_mode_t;

    // store transaction sequence
    typedef enum logic [1:0] {
        ST_IDLE,
        ST_WRITE,  // write valid raised, waiting for done
        ST_WRESP,  // waiting for the response pulse
        ST_FIN
    } store_state_t;

endpackage

/* design/rv_wb_params.svh */
`ifndef RV_WB_PARAMS_SVH
`define RV_WB_PARAMS_SVH

// data path width of the RV64 core
`define RV_XLEN 64

// general purpose register file geometry
`define RV_REG_NUM   32
`define RV_REG_IDX_W 5

// one mask bit per byte lane
`define RV_MASK_W 8

// raw store offset as delivered by decode
`define RV_IMM_W 32

`endif
